// File: bench/segre_tb_vectors.svh
`ifndef SEGRE_TB_VECTORS_SVH
`define SEGRE_TB_VECTORS_SVH

// Instruction word then expected status, rd, rf_we, value, br_taken and br_target
task automatic load_vectors();
    add_row(enc_i(12'h005, 0, 3'd0, 1, 7'h13), RES_OK, 1, 1, 32'h0000_0005, 0, 0);
    add_row(enc_i(12'hffd, 0, 3'd0, 2, 7'h13), RES_OK, 2, 1, 32'hffff_fffd, 0, 0);
    add_row(enc_r(7'h00, 2, 1, 3'd0, 3, 7'h33), RES_OK, 3, 1, 32'h0000_0002, 0, 0);
    add_row(enc_r(7'h20, 1, 3, 3'd0, 4, 7'h33), RES_OK, 4, 1, 32'hffff_fffd, 0, 0);
    add_row(enc_r(7'h00, 1, 4, 3'd2, 5, 7'h33), RES_OK, 5, 1, 32'h0000_0001, 0, 0);
    add_row(enc_r(7'h00, 1, 4, 3'd3, 6, 7'h33), RES_OK, 6, 1, 32'h0000_0000, 0, 0);
    add_row(enc_r(7'h00, 2, 1, 3'd4, 7, 7'h33), RES_OK, 7, 1, 32'hffff_fff8, 0, 0);
    add_row(enc_i(12'h004, 1, 3'd1, 8, 7'h13), RES_OK, 8, 1, 32'h0000_0050, 0, 0);
    add_row(enc_i(12'h401, 2, 3'd5, 9, 7'h13), RES_OK, 9, 1, 32'hffff_fffe, 0, 0);
    add_row(enc_i(12'h01c, 2, 3'd5, 10, 7'h13), RES_OK, 10, 1, 32'h0000_000f, 0, 0);
    add_row(enc_i(12'h0f0, 1, 3'd6, 11, 7'h13), RES_OK, 11, 1, 32'h0000_00f5, 0, 0);
    add_row(enc_i(12'h00f, 11, 3'd7, 12, 7'h13), RES_OK, 12, 1, 32'h0000_0005, 0, 0);
    add_row({20'h12345, 5'd13, 7'h37}, RES_OK, 13, 1, 32'h1234_5000, 0, 0);
    add_row({20'h00001, 5'd14, 7'h17}, RES_OK, 14, 1, 32'h0000_1134, 0, 0);
    add_row(enc_j(21'd16, 15), RES_OK, 15, 1, 32'h0000_013c, 1, 32'h0000_0148);
    add_row(enc_i(12'h008, 1, 3'd0, 16, 7'h67), RES_OK, 16, 1, 32'h0000_0140, 1, 32'h0000_000c);
    add_row(enc_b(13'd8, 1, 1, 3'd0), RES_OK, 8, 0, 0, 1, 32'h0000_0148);     // BEQ taken
    add_row(enc_b(13'd8, 2, 1, 3'd0), RES_OK, 8, 0, 0, 0, 32'h0000_014c);
    add_row(enc_b(-13'sd4, 2, 1, 3'd1), RES_OK, 29, 0, 0, 1, 32'h0000_0144); // BNE backward
    add_row(enc_b(13'd16, 1, 2, 3'd4), RES_OK, 16, 0, 0, 1, 32'h0000_015c);
    add_row(enc_b(13'd16, 1, 2, 3'd5), RES_OK, 16, 0, 0, 0, 32'h0000_0160);
    add_row(enc_b(13'd16, 1, 2, 3'd6), RES_OK, 16, 0, 0, 0, 32'h0000_0164);
    add_row(enc_b(13'd16, 1, 2, 3'd7), RES_OK, 16, 0, 0, 1, 32'h0000_0168);
    add_row(enc_b(13'd8, 1, 1, 3'd1), RES_OK, 8, 0, 0, 0, 32'h0000_0164);     // BNE not taken
    add_row(enc_b(13'd8, 2, 1, 3'd4), RES_OK, 8, 0, 0, 0, 32'h0000_0168);
    add_row(enc_b(13'd8, 2, 1, 3'd5), RES_OK, 8, 0, 0, 1, 32'h0000_016c);
    add_row(enc_b(13'd8, 2, 1, 3'd6), RES_OK, 8, 0, 0, 1, 32'h0000_0170);
    add_row(enc_b(13'd8, 2, 1, 3'd7), RES_OK, 8, 0, 0, 0, 32'h0000_0174);
    add_row(enc_i(12'h000, 1, 3'd2, 5, 7'h03), RES_UNSUPPORTED, 5, 0, 0, 0, 0);
    add_row(enc_r(7'h00, 1, 2, 3'd2, 0, 7'h23), RES_UNSUPPORTED, 0, 0, 0, 0, 0);
    add_row(enc_r(7'h01, 1, 1, 3'd0, 6, 7'h33), RES_UNSUPPORTED, 6, 0, 0, 0, 0);
    add_row(enc_i(12'h300, 1, 3'd1, 7, 7'h73), RES_UNSUPPORTED, 7, 0, 0, 0, 0);
    add_row(enc_i(12'h000, 0, 3'd0, 8, 7'h7f), RES_ILLEGAL, 8, 0, 0, 0, 0);
    add_row(enc_r(7'h00, 6, 5, 3'd0, 24, 7'h33), RES_OK, 24, 1, 32'h0000_0001, 0, 0);
    add_row(enc_r(7'h00, 8, 7, 3'd0, 25, 7'h33), RES_OK, 25, 1, 32'h0000_0048, 0, 0);
    add_row(enc_i(12'hff8, 25, 3'd0, 26, 7'h13), RES_OK, 26, 1, 32'h0000_0040, 0, 0);
    add_row(enc_r(7'h20, 1, 2, 3'd5, 27, 7'h33), RES_OK, 27, 1, 32'hffff_ffff, 0, 0);
    add_row(enc_r(7'h00, 1, 1, 3'd1, 28, 7'h33), RES_OK, 28, 1, 32'h0000_00a0, 0, 0);
    add_row(enc_r(7'h00, 26, 28, 3'd6, 29, 7'h33), RES_OK, 29, 1, 32'h0000_00e0, 0, 0);
    add_row(enc_r(7'h00, 11, 29, 3'd7, 30, 7'h33), RES_OK, 30, 1, 32'h0000_00e0, 0, 0);
    add_row(enc_r(7'h00, 1, 4, 3'd5, 31, 7'h33), RES_OK, 31, 1, 32'h07ff_ffff, 0, 0);
    add_row(enc_i(12'hffe, 2, 3'd2, 5, 7'h13), RES_OK, 5, 1, 32'h0000_0001, 0, 0);
    add_row(enc_i(12'h006, 1, 3'd3, 6, 7'h13), RES_OK, 6, 1, 32'h0000_0001, 0, 0);
    add_row(enc_i(12'hfff, 1, 3'd4, 7, 7'h13), RES_OK, 7, 1, 32'hffff_fffa, 0, 0);
endtask

`endif

// File: bench/segre_tb.sv
`timescale 1ns/10ps
`include "segre_settings.svh"

module segre_tb import segre_pkg::*; ();

logic       clk_i;
logic       reset_i;
logic       in_valid_i;
instr_pkt_t in_pkt_i;
logic       out_credit_i;
logic       in_credit_o;
logic       out_valid_o;
result_t    out_res_o;

logic [31:0] row_instr [$];
result_t     row_exp [$];
int          due_q [$];     // Cycles at which output credits go back
logic [31:0] lfsr_q;
int          cycle;
int          sent;
int          got;
int          in_credits;
int          core_credits;
int          credit_pulses;

segre_core i_dut (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .in_valid_i   (in_valid_i),
    .in_pkt_i     (in_pkt_i),
    .out_credit_i (out_credit_i),
    .in_credit_o  (in_credit_o),
    .out_valid_o  (out_valid_o),
    .out_res_o    (out_res_o)
);

function automatic logic [31:0] enc_i(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
                                      logic [6:0] opc);
    return {imm, 5'(rs1), f3, 5'(rd), opc};
endfunction

function automatic logic [31:0] enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
                                      int rd, logic [6:0] opc);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opc};
endfunction

function automatic logic [31:0] enc_b(logic [12:0] imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] enc_j(logic [20:0] imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'h6f};
endfunction

task automatic add_row(logic [31:0] instr, res_status_e st, int rd, logic we,
                       logic [31:0] value, logic taken, logic [31:0] target);
    result_t r;
    r.status    = st;
    r.rd        = 5'(rd);
    r.rf_we     = we;
    r.value     = value;
    r.br_taken  = taken;
    r.br_target = target;
    row_instr.push_back(instr);
    row_exp.push_back(r);
endtask

`include "segre_tb_vectors.svh"

// Galois form with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
endfunction

task automatic report_fail();
    $display("Simulation finished: FAIL");
    $fatal(1);
endtask

task automatic check_result(result_t exp, result_t act, int idx);
    if (act !== exp) begin
        $display("Fail out_res_o row %0d: got %h expected %h", idx, act, exp);
        report_fail();
    end
endtask

task automatic check_credits(string name, int value, int lo, int hi);
    if (value < lo || value > hi) begin
        $display("Fail %s: got %h expected %h to %h", name, value, lo, hi);
        report_fail();
    end
endtask

always #5 clk_i = ~clk_i;

always @(posedge clk_i) begin
    cycle++;
    if (cycle > 20 * row_exp.size() + 50) begin
        $display("Timeout: not all results and credits came back in time");
        $display("Simulation finished: FAIL");
        $fatal(1);
    end
end

always @(negedge clk_i) begin
    if (!reset_i) begin
        if (in_credit_o) begin
            in_credits++;
            credit_pulses++;
        end
        in_valid_i = 1'b0;
        if (sent < row_instr.size() && in_credits > 0) begin
            in_valid_i     = 1'b1;
            in_pkt_i.pc    = 32'h100 + 4 * sent;
            in_pkt_i.instr = row_instr[sent];
            in_credits--;
            sent++;
        end
        check_credits("in_credits", in_credits, 0, `SEGRE_IN_DEPTH);
        if (out_valid_o) begin
            if (got >= row_exp.size()) begin
                $display("Result emitted with no instruction left to match it");
                report_fail();
            end
            check_result(row_exp[got], out_res_o, got);
            got++;
            core_credits--;
            lfsr_q = lfsr_next(lfsr_q);
            due_q.push_back(cycle + 2 * lfsr_q[0]);
            lfsr_q = lfsr_next(lfsr_q);
            due_q[$] = due_q[$] + lfsr_q[0];
        end
        check_credits("core_credits", core_credits, 0, `SEGRE_OUT_CREDITS);
        out_credit_i = 1'b0;
        if (due_q.size() > 0 && due_q[0] <= cycle) begin
            void'(due_q.pop_front());
            out_credit_i = 1'b1;
            core_credits++;
        end
    end
end

initial begin
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    in_valid_i    = 1'b0;
    in_pkt_i      = '0;
    out_credit_i  = 1'b0;
    lfsr_q        = 32'hcb99;
    cycle         = 0;
    sent          = 0;
    got           = 0;
    credit_pulses = 0;
    in_credits    = `SEGRE_IN_DEPTH;
    core_credits  = `SEGRE_OUT_CREDITS;
    load_vectors();
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    while (got < row_exp.size() || credit_pulses < sent || due_q.size() > 0) begin
        @(posedge clk_i);
    end
    repeat (3) @(posedge clk_i);
    check_credits("in_credit_o pulses", credit_pulses, sent, sent);
    $display("Simulation finished: PASS");
    $finish;
end

endmodule

// File: hw/segre_core.sv
`timescale 1ns/10ps
`include "segre_settings.svh"

module segre_core import segre_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       in_valid_i,
    input  instr_pkt_t in_pkt_i,
    input  logic       out_credit_i,
    output logic       in_credit_o,
    output logic       out_valid_o,
    output result_t    out_res_o
);

logic       fq_valid;
instr_pkt_t fq_pkt;
logic       dec_valid;
decoded_t   dec;
logic       iss_valid;
issue_t     issue;
logic       stall;     // Execute holds a result with no credit left
logic       res_valid;
logic       wb;

segre_fetch_queue #(
    .DEPTH(`SEGRE_IN_DEPTH)
) i_fetch_queue (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .push_i     (in_valid_i),
    .push_pkt_i (in_pkt_i),
    .pop_i      (!stall),
    .valid_o    (fq_valid),
    .pkt_o      (fq_pkt),
    .credit_o   (in_credit_o)
);

segre_decode i_decode (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (fq_valid),
    .pkt_i   (fq_pkt),
    .stall_i (stall),
    .valid_o (dec_valid),
    .dec_o   (dec)
);

segre_operand i_operand (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .valid_i     (dec_valid),
    .dec_i       (dec),
    .stall_i     (stall),
    .fwd_valid_i (res_valid),
    .fwd_res_i   (out_res_o),
    .wb_i        (wb),
    .valid_o     (iss_valid),
    .issue_o     (issue)
);

segre_execute i_execute (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .valid_i      (iss_valid),
    .issue_i      (issue),
    .out_credit_i (out_credit_i),
    .out_valid_o  (out_valid_o),
    .out_res_o    (out_res_o),
    .stall_o      (stall),
    .res_valid_o  (res_valid),
    .wb_o         (wb)
);

endmodule

// File: hw/segre_decode.sv
`timescale 1ns/10ps
`include "segre_settings.svh"

module segre_decode import segre_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       valid_i,
    input  instr_pkt_t pkt_i,
    input  logic       stall_i,
    output logic       valid_o,
    output decoded_t   dec_o
);

logic [`SEGRE_XLEN-1:0] instr;
logic [`SEGRE_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
logic [2:0]             funct3;
logic [6:0]             funct7;
opcode_e                opcode;
alu_opcode_e            base_op;
pipeline_e              pipe;
logic                   rf_we;
logic                   illegal;
decoded_t               dec_d;

assign instr  = pkt_i.instr;
assign opcode = opcode_e'(instr[6:0]);
assign funct3 = instr[14:12];
assign funct7 = instr[31:25];

assign imm_i = {{20{instr[31]}}, instr[31:20]};
assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
assign imm_u = {instr[31:12], 12'b0};
assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

// Shared by OP and OP-IMM
always_comb begin
    unique case (funct3)
        3'b000:  base_op = ALU_ADD;
        3'b001:  base_op = ALU_SLL;
        3'b010:  base_op = ALU_SLT;
        3'b011:  base_op = ALU_SLTU;
        3'b100:  base_op = ALU_XOR;
        3'b101:  base_op = instr[30] ? ALU_SRA : ALU_SRL;
        3'b110:  base_op = ALU_OR;
        default: base_op = ALU_AND;
    endcase
end

always_comb begin
    rf_we   = 1'b0;
    pipe    = EX_PIPELINE;
    illegal = 1'b0;
    unique case (opcode)
        OPCODE_LUI, OPCODE_AUIPC, OPCODE_OP_IMM, OPCODE_JAL, OPCODE_JALR: rf_we = 1'b1;
        OPCODE_OP: begin
            if (funct7 == 7'b000_0001)
                pipe = RVM_PIPELINE;
            else
                rf_we = 1'b1;
        end
        OPCODE_LOAD, OPCODE_STORE: pipe = MEM_PIPELINE;
        OPCODE_SYSTEM: pipe = CSR_PIPELINE;
        OPCODE_BRANCH: ;
        default: illegal = 1'b1;
    endcase
end

always_comb begin
    dec_d.pc      = pkt_i.pc;
    dec_d.rs1     = instr[19:15];
    dec_d.rs2     = instr[24:20];
    dec_d.rd      = instr[11:7];
    dec_d.rf_we   = rf_we;
    dec_d.pipe    = pipe;
    dec_d.illegal = illegal;
    dec_d.alu_op  = ALU_ADD;
    dec_d.src_a   = ALU_A_REG;
    dec_d.src_b   = ALU_B_IMM; // Only OP takes rs2 as operand b
    dec_d.imm     = '0;
    unique case (opcode)
        OPCODE_LUI: begin
            dec_d.imm    = imm_u;
            dec_d.alu_op = ALU_PASS_B;
        end
        OPCODE_AUIPC: begin
            dec_d.src_a = ALU_A_PC;
            dec_d.imm   = imm_u;
        end
        OPCODE_OP_IMM: begin
            dec_d.imm    = imm_i;
            dec_d.alu_op = base_op;
        end
        OPCODE_OP: begin
            dec_d.src_b = ALU_B_REG;
            if (funct7 == 7'b000_0001) begin
                dec_d.alu_op = alu_opcode_e'(ALU_MUL + funct3);
            end else if (funct3 == 3'b000 && instr[30]) begin
                dec_d.alu_op = ALU_SUB;
            end else begin
                dec_d.alu_op = base_op;
            end
        end
        OPCODE_LOAD:  dec_d.imm = imm_i;
        OPCODE_STORE: dec_d.imm = imm_s;
        OPCODE_JAL: begin
            dec_d.src_a  = ALU_A_PC;
            dec_d.imm    = imm_j;
            dec_d.alu_op = ALU_JAL;
        end
        OPCODE_JALR: begin
            dec_d.imm    = imm_i;
            dec_d.alu_op = ALU_JALR;
        end
        OPCODE_BRANCH: begin
            dec_d.imm = imm_b; // Target offset, rs2 travels aside
            unique case (funct3)
                3'b000:  dec_d.alu_op = ALU_BEQ;
                3'b001:  dec_d.alu_op = ALU_BNE;
                3'b100:  dec_d.alu_op = ALU_BLT;
                3'b101:  dec_d.alu_op = ALU_BGE;
                3'b110:  dec_d.alu_op = ALU_BLTU;
                default: dec_d.alu_op = ALU_BGEU;
            endcase
        end
        default: ;
    endcase
end

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        valid_o <= 1'b0;
    end else if (!stall_i) begin
        valid_o <= valid_i;
    end
end

always_ff @(posedge clk_i) begin
    if (!stall_i) begin
        dec_o <= dec_d;
    end
end

endmodule

// File: hw/segre_execute.sv
`timescale 1ns/10ps
`include "segre_settings.svh"

module segre_execute import segre_pkg::*; (
    input  logic    clk_i,
    input  logic    reset_i,
    input  logic    valid_i,
    input  issue_t  issue_i,
    input  logic    out_credit_i,
    output logic    out_valid_o,
    output result_t out_res_o,
    output logic    stall_o,
    output logic    res_valid_o,
    output logic    wb_o
);

localparam int CW = $clog2(`SEGRE_OUT_CREDITS + 1);

logic [CW-1:0]          credit_q;
logic                   res_valid_q;
result_t                res_q;
result_t                res_d;
decoded_t               dec;
logic                   byp_a, byp_b;
logic [`SEGRE_XLEN-1:0] a, b, r2, sum;
logic [`SEGRE_XLEN-1:0] alu_val;
logic [`SEGRE_XLEN-1:0] target;
logic                   taken;
logic                   exec_ok;

function automatic logic branch_cond(alu_opcode_e op, logic [`SEGRE_XLEN-1:0] x,
                                     logic [`SEGRE_XLEN-1:0] y);
    unique case (op)
        ALU_BEQ:  return x == y;
        ALU_BNE:  return x != y;
        ALU_BLT:  return $signed(x) < $signed(y);
        ALU_BGE:  return $signed(x) >= $signed(y);
        ALU_BLTU: return x < y;
        default:  return x >= y;
    endcase
endfunction

assign dec = issue_i.dec;

// Result of the instruction just ahead, not yet in the register file
assign byp_a = res_valid_q && res_q.rf_we && (res_q.rd == dec.rs1) && (dec.rs1 != '0);
assign byp_b = res_valid_q && res_q.rf_we && (res_q.rd == dec.rs2) && (dec.rs2 != '0);

assign a   = (byp_a && dec.src_a == ALU_A_REG) ? res_q.value : issue_i.op_a;
assign b   = (byp_b && dec.src_b == ALU_B_REG) ? res_q.value : issue_i.op_b;
assign r2  = byp_b ? res_q.value : issue_i.rs2_val;
assign sum = a + b;

always_comb begin
    alu_val = '0;
    taken   = 1'b0;
    target  = '0;
    unique case (dec.alu_op)
        ALU_ADD:    alu_val = sum;
        ALU_SUB:    alu_val = a - b;
        ALU_SLL:    alu_val = a << b[4:0];
        ALU_SLT:    alu_val = `SEGRE_XLEN'($signed(a) < $signed(b));
        ALU_SLTU:   alu_val = `SEGRE_XLEN'(a < b);
        ALU_XOR:    alu_val = a ^ b;
        ALU_SRL:    alu_val = a >> b[4:0];
        ALU_SRA:    alu_val = $unsigned($signed(a) >>> b[4:0]);
        ALU_OR:     alu_val = a | b;
        ALU_AND:    alu_val = a & b;
        ALU_PASS_B: alu_val = b;
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU: begin
            taken  = branch_cond(dec.alu_op, a, r2);
            target = dec.pc + dec.imm;
        end
        ALU_JAL, ALU_JALR: begin
            alu_val = dec.pc + 4; // Link address
            taken   = 1'b1;
            target  = {sum[`SEGRE_XLEN-1:1], sum[0] & (dec.alu_op == ALU_JAL)};
        end
        default: ;
    endcase
end

always_comb begin
    res_d.rd     = dec.rd;
    res_d.status = RES_OK;
    if (dec.illegal)
        res_d.status = RES_ILLEGAL;
    else if (dec.pipe != EX_PIPELINE)
        res_d.status = RES_UNSUPPORTED;
    exec_ok         = (res_d.status == RES_OK);
    res_d.rf_we     = dec.rf_we && exec_ok;
    res_d.value     = exec_ok ? alu_val : '0;
    res_d.br_taken  = exec_ok && taken;
    res_d.br_target = exec_ok ? target : '0;
end

assign out_valid_o = res_valid_q && (credit_q != '0);
assign stall_o     = res_valid_q && (credit_q == '0);
assign out_res_o   = res_q;
assign res_valid_o = res_valid_q;
assign wb_o        = out_valid_o; // Register file takes the result as it leaves

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        res_valid_q <= 1'b0;
        credit_q    <= CW'(`SEGRE_OUT_CREDITS);
    end else begin
        if (!stall_o)
            res_valid_q <= valid_i;
        credit_q <= credit_q + CW'(out_credit_i) - CW'(out_valid_o);
    end
end

always_ff @(posedge clk_i) begin
    if (!stall_o) begin
        res_q <= res_d;
    end
end

endmodule

// File: hw/segre_fetch_queue.sv
`timescale 1ns/10ps
`include "segre_settings.svh"

module segre_fetch_queue import segre_pkg::*; #(
    parameter int DEPTH = `SEGRE_IN_DEPTH
) (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       push_i,
    input  instr_pkt_t push_pkt_i,
    input  logic       pop_i,
    output logic       valid_o,
    output instr_pkt_t pkt_o,
    output logic       credit_o
);

localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CW = $clog2(DEPTH + 1);

instr_pkt_t    mem_q [DEPTH];
logic [PW-1:0] rd_ptr_q;
logic [PW-1:0] wr_ptr_q;
logic [CW-1:0] count_q;
logic          do_pop;

assign valid_o = (count_q != '0);
assign pkt_o   = mem_q[rd_ptr_q];
assign do_pop  = valid_o && pop_i;

always_ff @(posedge clk_i) begin
    if (push_i) begin
        mem_q[wr_ptr_q] <= push_pkt_i; // Sender credits keep this from overflowing
    end
end

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        rd_ptr_q <= '0;
        wr_ptr_q <= '0;
        count_q  <= '0;
        credit_o <= 1'b0;
    end else begin
        if (push_i) begin
            wr_ptr_q <= (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (do_pop) begin
            rd_ptr_q <= (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        count_q  <= count_q + CW'(push_i) - CW'(do_pop);
        credit_o <= do_pop; // One credit back per entry handed on
    end
end

endmodule

// File: hw/segre_operand.sv
`timescale 1ns/10ps
`include "segre_settings.svh"

module segre_operand import segre_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     valid_i,
    input  decoded_t dec_i,
    input  logic     stall_i,
    input  logic     fwd_valid_i,
    input  result_t  fwd_res_i,
    input  logic     wb_i,
    output logic     valid_o,
    output issue_t   issue_o
);

logic [`SEGRE_XLEN-1:0] rf_q [2**`SEGRE_REG_ADDR];
logic [`SEGRE_XLEN-1:0] rs1_val;
logic [`SEGRE_XLEN-1:0] rs2_val;
logic                   fwd_hit1;
logic                   fwd_hit2;

always_ff @(posedge clk_i) begin
    if (wb_i && fwd_res_i.rf_we) begin
        rf_q[fwd_res_i.rd] <= fwd_res_i.value;
    end
end

// The execute register is also the result being written this cycle
assign fwd_hit1 = fwd_valid_i && fwd_res_i.rf_we && (fwd_res_i.rd == dec_i.rs1);
assign fwd_hit2 = fwd_valid_i && fwd_res_i.rf_we && (fwd_res_i.rd == dec_i.rs2);

assign rs1_val = (dec_i.rs1 == '0) ? '0 : (fwd_hit1 ? fwd_res_i.value : rf_q[dec_i.rs1]);
assign rs2_val = (dec_i.rs2 == '0) ? '0 : (fwd_hit2 ? fwd_res_i.value : rf_q[dec_i.rs2]);

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        valid_o <= 1'b0;
    end else if (!stall_i) begin
        valid_o <= valid_i;
    end
end

always_ff @(posedge clk_i) begin
    if (!stall_i) begin
        issue_o.dec     <= dec_i;
        issue_o.op_a    <= (dec_i.src_a == ALU_A_PC) ? dec_i.pc : rs1_val;
        issue_o.op_b    <= (dec_i.src_b == ALU_B_IMM) ? dec_i.imm : rs2_val;
        issue_o.rs2_val <= rs2_val;
    end
end

endmodule

// File: hw/segre_pkg.sv
`include "segre_settings.svh"

package segre_pkg;

typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JALR   = 7'h67,
    OPCODE_JAL    = 7'h6f,
    OPCODE_SYSTEM = 7'h73
} opcode_e;

typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
    ALU_JAL, ALU_JALR, ALU_PASS_B,
    ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU, // Kept in funct3 order
    ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
} alu_opcode_e;

typedef enum logic [0:0] {ALU_A_REG, ALU_A_PC} alu_src_a_e;
typedef enum logic [0:0] {ALU_B_REG, ALU_B_IMM} alu_src_b_e;
typedef enum logic [1:0] {EX_PIPELINE, MEM_PIPELINE, RVM_PIPELINE, CSR_PIPELINE} pipeline_e;
typedef enum logic [1:0] {RES_OK, RES_ILLEGAL, RES_UNSUPPORTED} res_status_e;

typedef struct packed {
    logic [`SEGRE_XLEN-1:0] pc;
    logic [`SEGRE_XLEN-1:0] instr;
} instr_pkt_t;

typedef struct packed {
    logic [`SEGRE_XLEN-1:0]     pc;
    alu_opcode_e                alu_op;
    alu_src_a_e                 src_a;
    alu_src_b_e                 src_b;
    pipeline_e                  pipe;
    logic [`SEGRE_REG_ADDR-1:0] rs1;
    logic [`SEGRE_REG_ADDR-1:0] rs2;
    logic [`SEGRE_REG_ADDR-1:0] rd;
    logic                       rf_we;
    logic [`SEGRE_XLEN-1:0]     imm;    // Already selected per opcode
    logic                       illegal;
} decoded_t;

typedef struct packed {
    decoded_t               dec;
    logic [`SEGRE_XLEN-1:0] op_a;
    logic [`SEGRE_XLEN-1:0] op_b;
    logic [`SEGRE_XLEN-1:0] rs2_val; // Branch compare operand
} issue_t;

typedef struct packed {
    res_status_e                status;
    logic [`SEGRE_REG_ADDR-1:0] rd;
    logic                       rf_we;
    logic [`SEGRE_XLEN-1:0]     value;
    logic                       br_taken;
    logic [`SEGRE_XLEN-1:0]     br_target;
} result_t;

endpackage

// File: hw/segre_settings.svh
`ifndef SEGRE_SETTINGS_SVH
`define SEGRE_SETTINGS_SVH

`define SEGRE_XLEN 32
`define SEGRE_REG_ADDR 5

// Stream flow control
`define SEGRE_IN_DEPTH 4
`define SEGRE_OUT_CREDITS 2

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the segre_lite testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -j 0 -Wno-fatal --top-module segre_tb -f segre_lite.f

obj_dir/Vsegre_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    exit 1
fi

// File: segre_lite.f
+incdir+hw
+incdir+bench
hw/segre_pkg.sv
hw/segre_fetch_queue.sv
hw/segre_decode.sv
hw/segre_operand.sv
hw/segre_execute.sv
hw/segre_core.sv
bench/segre_tb.sv
